// File: rename_core.f
+incdir+common
+incdir+testbench
common/rename_pkg.sv
common/rename_map_if.sv
rename_table/rename_map_table.sv
rename_table/rename_free_list.sv
source/rename_stage.sv
source/rename_core.sv
testbench/tb_rename_core.sv

// File: Bender.yml
package:
  name: rename_core

export_include_dirs:
  - common

sources:
  - common/rename_pkg.sv
  - common/rename_map_if.sv
  - rename_table/rename_map_table.sv
  - rename_table/rename_free_list.sv
  - source/rename_stage.sv
  - source/rename_core.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_rename_core.sv

// File: testbench/tb_rename_checks.svh
`ifndef TB_RENAME_CHECKS_SVH
`define TB_RENAME_CHECKS_SVH

// Expected maps and both views of the free list.
rename_pkg::preg_t          spec_map [`NUM_LREGS];
rename_pkg::preg_t          comm_map [`NUM_LREGS];
rename_pkg::preg_t          free_q [$];
rename_pkg::preg_t          comm_q [$];
rename_pkg::ren_info_t      inflight_q [$];
rename_pkg::ren_info_t      exp_out [`RENAME_WIDTH];
logic [`RENAME_WIDTH-1:0]   exp_vld;

task automatic check_ren_info(input string name, input rename_pkg::ren_info_t exp,
                              input rename_pkg::ren_info_t act);
    if (act !== exp) begin
        $display("** Error %s: expected %h, actual %h", name, exp, act);
        n_err++;
    end
endtask

task automatic check_stall(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("** Error %s: expected stall %b, actual %b", name, exp, act);
        n_err++;
    end
endtask

task automatic check_vld(input string name, input logic [`RENAME_WIDTH-1:0] exp,
                         input logic [`RENAME_WIDTH-1:0] act);
    if (act !== exp) begin
        $display("** Error %s: expected valid %b, actual %b", name, exp, act);
        n_err++;
    end
endtask

function automatic void model_reset();
    free_q = {};
    comm_q = {};
    inflight_q = {};
    exp_vld = '0;
    for (int r = 0; r < `NUM_LREGS; r++) begin
        spec_map[r] = rename_pkg::preg_t'(r);
        comm_map[r] = rename_pkg::preg_t'(r);
    end
    for (int e = 0; e < `FREE_DEPTH; e++) begin
        free_q.push_back(rename_pkg::preg_t'(`NUM_LREGS + e));
        comm_q.push_back(rename_pkg::preg_t'(`NUM_LREGS + e));
    end
endfunction

// One cycle of decode input, output checked after the next edge.
task automatic drive_group(input string name, input logic [`RENAME_WIDTH-1:0] vld,
                           input rename_pkg::dec_info_t d0, input rename_pkg::dec_info_t d1);
    rename_pkg::dec_info_t      d [`RENAME_WIDTH];
    logic [`RENAME_WIDTH-1:0]   req;
    int                         nreq;
    logic                       exp_stall;
    d[0] = d0;
    d[1] = d1;
    dec_vld = vld;
    dec_info = d;
    nreq = 0;
    for (int s = 0; s < `RENAME_WIDTH; s++) begin
        req[s] = vld[s] && d[s].rd_wen && d[s].lrd != '0;
        nreq += req[s];
    end
    exp_stall = stall_in || (free_q.size() < nreq);
    #1;
    check_stall(name, exp_stall, stall_out);
    if (!exp_stall && vld != '0) begin
        // Older slot updates the map first, which gives the bypass.
        for (int s = 0; s < `RENAME_WIDTH; s++) begin
            exp_out[s] = '0;
            exp_out[s].rd_wen = d[s].rd_wen;
            exp_out[s].lrd = d[s].lrd;
            exp_out[s].lrs = d[s].lrs;
            exp_out[s].uop = d[s].uop;
            for (int k = 0; k < `NUMSRCS; k++) begin
                exp_out[s].prs[k] = spec_map[d[s].lrs[k]];
            end
            if (req[s]) begin
                exp_out[s].prev_prd = spec_map[d[s].lrd];
                exp_out[s].prd = free_q.pop_front();
                spec_map[d[s].lrd] = exp_out[s].prd;
                inflight_q.push_back(exp_out[s]);
            end
        end
        exp_vld = vld;
    end else if (!stall_in) begin
        exp_vld = '0;
    end
    @(posedge clk);
    #1;
    dec_vld = '0;
    check_vld(name, exp_vld, ren_vld);
    for (int s = 0; s < `RENAME_WIDTH; s++) begin
        if (exp_vld[s]) begin
            check_ren_info(name, exp_out[s], ren_info[s]);
        end
    end
endtask

// Retires the oldest renamed destinations in order.
task automatic commit_group(input int n);
    rename_pkg::commit_info_t   c [`COMMIT_WIDTH];
    rename_pkg::ren_info_t      r;
    c = '{default: '0};
    commit_vld = '0;
    for (int i = 0; i < n; i++) begin
        r = inflight_q.pop_front();
        c[i].rd_wen = 1'b1;
        c[i].lrd = r.lrd;
        c[i].prd = r.prd;
        c[i].prev_prd = r.prev_prd;
        commit_vld[i] = 1'b1;
        comm_map[r.lrd] = r.prd;
        free_q.push_back(r.prev_prd);
        comm_q.push_back(r.prev_prd);
        void'(comm_q.pop_front());
    end
    commit_info = c;
    @(posedge clk);
    #1;
    commit_vld = '0;
    exp_vld = '0;
endtask

// A group offered in the squash cycle is dropped.
task automatic squash(input string name, input rename_pkg::dec_info_t d0);
    dec_vld = 2'b01;
    dec_info[0] = d0;
    squash_in = 1'b1;
    @(posedge clk);
    #1;
    squash_in = 1'b0;
    dec_vld = '0;
    check_vld(name, '0, ren_vld);
    spec_map = comm_map;
    free_q = comm_q;
    inflight_q = {};
    exp_vld = '0;
endtask

`endif

// File: testbench/tb_rename_core.sv
`timescale 1ns/10ps

`include "rename_macros.svh"

module tb_rename_core;

    // Reset and all tests take about 100 cycles.
    localparam int TIMEOUT_CYCLES = 2000;

    logic                       clk;
    logic                       rst_n;
    logic [`RENAME_WIDTH-1:0]   dec_vld;
    rename_pkg::dec_info_t      dec_info [`RENAME_WIDTH];
    logic                       stall_in;
    logic                       squash_in;
    logic [`COMMIT_WIDTH-1:0]   commit_vld;
    rename_pkg::commit_info_t   commit_info [`COMMIT_WIDTH];
    logic                       stall_out;
    logic [`RENAME_WIDTH-1:0]   ren_vld;
    rename_pkg::ren_info_t      ren_info [`RENAME_WIDTH];

    int          seed = 32'hd717;
    int          n_err = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          cycles = 0;
    logic [15:0] uop_cnt;

    `include "tb_rename_checks.svh"

    rename_core DUT (
        .clk            (clk),
        .i_rst_n        (rst_n),
        .i_dec_vld      (dec_vld),
        .i_dec_info     (dec_info),
        .i_stall        (stall_in),
        .i_squash       (squash_in),
        .i_commit_vld   (commit_vld),
        .i_commit_info  (commit_info),
        .o_stall        (stall_out),
        .o_ren_vld      (ren_vld),
        .o_ren_info     (ren_info)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic rename_pkg::dec_info_t make_dec(input logic wen, input int lrd,
                                                       input int rs0, input int rs1);
        rename_pkg::dec_info_t d;
        d.rd_wen = wen;
        d.lrd = rename_pkg::lreg_t'(lrd);
        d.lrs[0] = rename_pkg::lreg_t'(rs0);
        d.lrs[1] = rename_pkg::lreg_t'(rs1);
        d.uop = uop_cnt;
        uop_cnt++;
        return d;
    endfunction

    function automatic int rand_lreg(input int lo);
        return lo + ($unsigned($random(seed)) % (`NUM_LREGS - lo));
    endfunction

    function automatic void report_test(input string name, input int errs_before);
        if (n_err == errs_before) begin
            n_pass++;
            $display("%s: PASS", name);
        end else begin
            n_fail++;
            $display("%s: FAIL", name);
        end
    endfunction

    task automatic test_reset_state();
        int errs;
        errs = n_err;
        check_vld("reset_vld", '0, ren_vld);
        drive_group("reset_lookup", 2'b11, make_dec(0, 0, rand_lreg(0), rand_lreg(0)),
                    make_dec(0, 0, rand_lreg(0), rand_lreg(0)));
        report_test("reset_state", errs);
    endtask

    task automatic test_alloc_order();
        int errs;
        errs = n_err;
        drive_group("alloc_pair", 2'b11, make_dec(1, 5, 1, 2), make_dec(1, 6, 3, 4));
        drive_group("alloc_reuse", 2'b01, make_dec(1, 5, 5, 6), make_dec(0, 0, 0, 0));
        drive_group("alloc_none", 2'b11, make_dec(1, 0, 5, 6), make_dec(0, 7, 5, 6));
        report_test("alloc_order", errs);
    endtask

    task automatic test_bypass();
        int errs;
        errs = n_err;
        drive_group("bypass_src", 2'b11, make_dec(1, 9, 1, 2), make_dec(1, 10, 9, 9));
        drive_group("bypass_dst", 2'b11, make_dec(1, 11, 0, 0), make_dec(1, 11, 11, 0));
        report_test("bypass", errs);
    endtask

    task automatic test_stall();
        int errs;
        errs = n_err;
        stall_in = 1'b1;
        drive_group("stall_hold", 2'b01, make_dec(1, 3, 1, 2), make_dec(0, 0, 0, 0));
        stall_in = 1'b0;
        // Drain the free list one register at a time.
        while (free_q.size() > 0) begin
            drive_group("stall_fill", 2'b01,
                        make_dec(1, rand_lreg(1), rand_lreg(0), rand_lreg(0)),
                        make_dec(0, 0, 0, 0));
        end
        drive_group("stall_empty", 2'b01, make_dec(1, 4, 0, 0), make_dec(0, 0, 0, 0));
        commit_group(1);
        drive_group("stall_release", 2'b01, make_dec(1, 4, 4, 0), make_dec(0, 0, 0, 0));
        report_test("stall", errs);
    endtask

    task automatic test_squash_reuse();
        int errs;
        errs = n_err;
        commit_group(2);
        commit_group(2);
        drive_group("squash_spec", 2'b11, make_dec(1, 5, 5, 6), make_dec(1, 6, 5, 6));
        squash("squash_flush", make_dec(1, 7, 5, 6));
        drive_group("squash_lookup", 2'b11, make_dec(0, 0, 5, 6), make_dec(0, 0, 9, 11));
        while (free_q.size() > 0) begin
            drive_group("squash_refill", 2'b11,
                        make_dec(1, rand_lreg(1), rand_lreg(0), rand_lreg(0)),
                        make_dec(1, rand_lreg(1), rand_lreg(0), rand_lreg(0)));
        end
        report_test("squash_reuse", errs);
    endtask

    initial begin
        rst_n = 1'b0;
        dec_vld = '0;
        dec_info = '{default: '0};
        stall_in = 1'b0;
        squash_in = 1'b0;
        commit_vld = '0;
        commit_info = '{default: '0};
        uop_cnt = '0;
        model_reset();
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_state();
        test_alloc_order();
        test_bypass();
        test_stall();
        test_squash_reuse();
        $display("Tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, n_err);
        if (n_fail == 0 && n_err == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: source/rename_core.sv
`timescale 1ns/10ps

`include "rename_macros.svh"

module rename_core (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic [`RENAME_WIDTH-1:0]    i_dec_vld,
    input  rename_pkg::dec_info_t       i_dec_info [`RENAME_WIDTH],
    input  logic                        i_stall,
    input  logic                        i_squash,
    input  logic [`COMMIT_WIDTH-1:0]    i_commit_vld,
    input  rename_pkg::commit_info_t    i_commit_info [`COMMIT_WIDTH],
    output logic                        o_stall,
    output logic [`RENAME_WIDTH-1:0]    o_ren_vld,
    output rename_pkg::ren_info_t       o_ren_info [`RENAME_WIDTH]
);

    logic                       can_alloc;
    logic [`RENAME_WIDTH-1:0]   alloc_req;
    logic [`RENAME_WIDTH-1:0]   alloc_fire;
    rename_pkg::preg_t          alloc_prd [`RENAME_WIDTH];

    rename_map_if u_map_if ();

    rename_stage u_stage (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_dec_vld      (i_dec_vld),
        .i_dec_info     (i_dec_info),
        .i_stall        (i_stall),
        .i_squash       (i_squash),
        .i_can_alloc    (can_alloc),
        .i_alloc_prd    (alloc_prd),
        .o_alloc_req    (alloc_req),
        .o_alloc_fire   (alloc_fire),
        .map            (u_map_if.stage),
        .o_stall        (o_stall),
        .o_ren_vld      (o_ren_vld),
        .o_ren_info     (o_ren_info)
    );

    rename_map_table u_map_table (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .map            (u_map_if.tbl),
        .i_squash       (i_squash),
        .i_commit_vld   (i_commit_vld),
        .i_commit_info  (i_commit_info)
    );

    rename_free_list u_free_list (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_alloc_req    (alloc_req),
        .i_alloc_fire   (alloc_fire),
        .o_alloc_prd    (alloc_prd),
        .o_can_alloc    (can_alloc),
        .i_squash       (i_squash),
        .i_commit_vld   (i_commit_vld),
        .i_commit_info  (i_commit_info)
    );

endmodule

// File: source/rename_stage.sv
`timescale 1ns/10ps

`include "rename_macros.svh"

module rename_stage (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic [`RENAME_WIDTH-1:0]    i_dec_vld,
    input  rename_pkg::dec_info_t       i_dec_info [`RENAME_WIDTH],
    input  logic                        i_stall,
    input  logic                        i_squash,
    input  logic                        i_can_alloc,
    input  rename_pkg::preg_t           i_alloc_prd [`RENAME_WIDTH],
    output logic [`RENAME_WIDTH-1:0]    o_alloc_req,
    output logic [`RENAME_WIDTH-1:0]    o_alloc_fire,
    rename_map_if.stage                 map,
    output logic                        o_stall,
    output logic [`RENAME_WIDTH-1:0]    o_ren_vld,
    output rename_pkg::ren_info_t       o_ren_info [`RENAME_WIDTH]
);

    logic                       accept;
    rename_pkg::ren_info_t      ren_next [`RENAME_WIDTH];

    assign o_stall      = i_stall || !i_can_alloc;
    assign accept       = (|i_dec_vld) && !o_stall && !i_squash;
    assign o_alloc_fire = accept ? o_alloc_req : '0;

    always_comb begin
        for (int s = 0; s < `RENAME_WIDTH; s++) begin
            o_alloc_req[s] = i_dec_vld[s] && i_dec_info[s].rd_wen
                             && i_dec_info[s].lrd != '0;
            map.lrd[s]     = i_dec_info[s].lrd;
            map.new_prd[s] = i_alloc_prd[s];
            for (int k = 0; k < `NUMSRCS; k++) begin
                map.lookup_lrs[s][k] = i_dec_info[s].lrs[k];
            end
        end
    end

    // Map writes only for slots of an accepted group.
    assign map.wr_en = o_alloc_fire;

    always_comb begin
        for (int s = 0; s < `RENAME_WIDTH; s++) begin
            ren_next[s].rd_wen   = i_dec_info[s].rd_wen;
            ren_next[s].lrd      = i_dec_info[s].lrd;
            ren_next[s].lrs      = i_dec_info[s].lrs;
            ren_next[s].uop      = i_dec_info[s].uop;
            // No destination, no physical register.
            ren_next[s].prd      = o_alloc_req[s] ? i_alloc_prd[s] : '0;
            ren_next[s].prev_prd = o_alloc_req[s] ? map.prev_prd[s] : '0;
            for (int k = 0; k < `NUMSRCS; k++) begin
                ren_next[s].prs[k] = map.prs[s][k];
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ren_vld <= '0;
        end else if (i_squash) begin
            o_ren_vld <= '0;
        end else if (!i_stall) begin
            o_ren_vld <= accept ? i_dec_vld : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall && !i_squash) begin
            o_ren_info <= ren_next;
        end
    end

endmodule

// File: rename_table/rename_free_list.sv
`timescale 1ns/10ps

`include "rename_macros.svh"

module rename_free_list (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic [`RENAME_WIDTH-1:0]    i_alloc_req,
    input  logic [`RENAME_WIDTH-1:0]    i_alloc_fire,
    output rename_pkg::preg_t           o_alloc_prd [`RENAME_WIDTH],
    output logic                        o_can_alloc,
    input  logic                        i_squash,
    input  logic [`COMMIT_WIDTH-1:0]    i_commit_vld,
    input  rename_pkg::commit_info_t    i_commit_info [`COMMIT_WIDTH]
);

    localparam int PTR_W = $clog2(`FREE_DEPTH);
    localparam int CNT_W = $clog2(`FREE_DEPTH + 1);

    rename_pkg::preg_t  ring [`FREE_DEPTH];
    logic [PTR_W-1:0]   spec_rd;
    logic [PTR_W-1:0]   comm_rd;
    logic [PTR_W-1:0]   wr_ptr;
    logic [CNT_W-1:0]   spec_cnt;

    logic [CNT_W-1:0]   n_req;
    logic [CNT_W-1:0]   n_fire;
    logic [CNT_W-1:0]   n_free;
    logic [`COMMIT_WIDTH-1:0] free_en;
    logic [PTR_W-1:0]   free_off [`COMMIT_WIDTH];

    // Requests take consecutive entries from the read pointer.
    always_comb begin
        n_req  = '0;
        n_fire = '0;
        for (int s = 0; s < `RENAME_WIDTH; s++) begin
            o_alloc_prd[s] = ring[spec_rd + PTR_W'(n_req)];
            n_req  = n_req + CNT_W'(i_alloc_req[s]);
            n_fire = n_fire + CNT_W'(i_alloc_fire[s]);
        end
    end

    assign o_can_alloc = (spec_cnt >= n_req);

    // Freed registers pack in commit order.
    always_comb begin
        n_free = '0;
        for (int c = 0; c < `COMMIT_WIDTH; c++) begin
            free_en[c]  = i_commit_vld[c] && i_commit_info[c].rd_wen
                          && i_commit_info[c].lrd != '0;
            free_off[c] = PTR_W'(n_free);
            n_free      = n_free + CNT_W'(free_en[c]);
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int e = 0; e < `FREE_DEPTH; e++) begin
                ring[e] <= rename_pkg::preg_t'(`NUM_LREGS + e);
            end
            spec_rd  <= '0;
            comm_rd  <= '0;
            wr_ptr   <= '0;
            spec_cnt <= CNT_W'(`FREE_DEPTH);
        end else begin
            for (int c = 0; c < `COMMIT_WIDTH; c++) begin
                if (free_en[c]) begin
                    ring[wr_ptr + free_off[c]] <= i_commit_info[c].prev_prd;
                end
            end
            wr_ptr  <= wr_ptr + PTR_W'(n_free);
            comm_rd <= comm_rd + PTR_W'(n_free);
            if (i_squash) begin
                // Committed side always holds a full ring.
                spec_rd  <= comm_rd + PTR_W'(n_free);
                spec_cnt <= CNT_W'(`FREE_DEPTH);
            end else begin
                spec_rd  <= spec_rd + PTR_W'(n_fire);
                spec_cnt <= spec_cnt - n_fire + n_free;
            end
        end
    end

endmodule

// File: rename_table/rename_map_table.sv
`timescale 1ns/10ps

`include "rename_macros.svh"

module rename_map_table (
    input  logic                        clk,
    input  logic                        i_rst_n,
    rename_map_if.tbl                   map,
    input  logic                        i_squash,
    input  logic [`COMMIT_WIDTH-1:0]    i_commit_vld,
    input  rename_pkg::commit_info_t    i_commit_info [`COMMIT_WIDTH]
);

    rename_pkg::preg_t spec_map [`NUM_LREGS];
    rename_pkg::preg_t comm_map [`NUM_LREGS];
    rename_pkg::preg_t comm_next [`NUM_LREGS];

    // Source lookup, forwarded from older destinations in the group.
    always_comb begin
        for (int s = 0; s < `RENAME_WIDTH; s++) begin
            for (int k = 0; k < `NUMSRCS; k++) begin
                map.prs[s][k] = spec_map[map.lookup_lrs[s][k]];
                for (int j = 0; j < s; j++) begin
                    if (map.wr_en[j] && map.lrd[j] == map.lookup_lrs[s][k]) begin
                        map.prs[s][k] = map.new_prd[j];
                    end
                end
            end
        end
    end

    // Replaced mapping of each destination.
    always_comb begin
        for (int s = 0; s < `RENAME_WIDTH; s++) begin
            map.prev_prd[s] = spec_map[map.lrd[s]];
            for (int j = 0; j < s; j++) begin
                if (map.wr_en[j] && map.lrd[j] == map.lrd[s]) begin
                    map.prev_prd[s] = map.new_prd[j];
                end
            end
        end
    end

    // Committed map with this cycle's retirements applied in order.
    always_comb begin
        comm_next = comm_map;
        for (int c = 0; c < `COMMIT_WIDTH; c++) begin
            if (i_commit_vld[c] && i_commit_info[c].rd_wen && i_commit_info[c].lrd != '0) begin
                comm_next[i_commit_info[c].lrd] = i_commit_info[c].prd;
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int r = 0; r < `NUM_LREGS; r++) begin
                spec_map[r] <= rename_pkg::preg_t'(r);
                comm_map[r] <= rename_pkg::preg_t'(r);
            end
        end else begin
            comm_map <= comm_next;
            if (i_squash) begin
                spec_map <= comm_next;
            end else begin
                // Younger slot wins on a shared destination.
                for (int s = 0; s < `RENAME_WIDTH; s++) begin
                    if (map.wr_en[s]) begin
                        spec_map[map.lrd[s]] <= map.new_prd[s];
                    end
                end
            end
        end
    end

endmodule

// File: common/rename_map_if.sv
`timescale 1ns/10ps

`include "rename_macros.svh"

interface rename_map_if;

    rename_pkg::lreg_t              lookup_lrs [`RENAME_WIDTH][`NUMSRCS];
    logic [`RENAME_WIDTH-1:0]       wr_en;
    rename_pkg::lreg_t              lrd [`RENAME_WIDTH];
    rename_pkg::preg_t              new_prd [`RENAME_WIDTH];

    // Answers from the table, combinational.
    rename_pkg::preg_t              prs [`RENAME_WIDTH][`NUMSRCS];
    rename_pkg::preg_t              prev_prd [`RENAME_WIDTH];

    modport stage (
        output lookup_lrs,
        output wr_en,
        output lrd,
        output new_prd,
        input  prs,
        input  prev_prd
    );

    modport tbl (
        input  lookup_lrs,
        input  wr_en,
        input  lrd,
        input  new_prd,
        output prs,
        output prev_prd
    );

endinterface

// File: common/rename_pkg.sv
`include "rename_macros.svh"

package rename_pkg;

    typedef logic [$clog2(`NUM_LREGS)-1:0] lreg_t;
    typedef logic [$clog2(`NUM_PREGS)-1:0] preg_t;

    // Decoded instruction as seen by rename.
    typedef struct packed {
        logic                      rd_wen;
        lreg_t                     lrd;
        lreg_t [`NUMSRCS-1:0]      lrs;
        logic [15:0]               uop;
    } dec_info_t;

    // Renamed instruction handed to dispatch.
    typedef struct packed {
        logic                      rd_wen;
        lreg_t                     lrd;
        lreg_t [`NUMSRCS-1:0]      lrs;
        logic [15:0]               uop;
        preg_t                     prd;
        preg_t                     prev_prd;
        preg_t [`NUMSRCS-1:0]      prs;
    } ren_info_t;

    // Retiring instruction.
    typedef struct packed {
        logic                      rd_wen;
        lreg_t                     lrd;
        preg_t                     prd;
        preg_t                     prev_prd;
    } commit_info_t;

endpackage

// File: common/rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// Instructions renamed per cycle.
`define RENAME_WIDTH 2

// Source operands per instruction.
`define NUMSRCS 2

// Commits per cycle.
`define COMMIT_WIDTH 2

// Register file sizes.
`define NUM_LREGS 32
`define NUM_PREGS 64

// Physical registers not held by the committed map.
`define FREE_DEPTH (`NUM_PREGS - `NUM_LREGS)

`endif
